// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing -Wno-fatal --top-module flash_tb -Mdir obj_dir -f project.f
	./obj_dir/Vflash_tb | tee sim.log
	grep -q "ALL CHECKS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

// File: design/flash.sv
`timescale 1ns/1ps
`include "flash_settings.svh"

module flash (
	input  logic                     wb_clk_i,
	input  logic                     arst_n_i,

	// wishbone slave, read only
	input  logic                     wb_cyc_i,
	input  logic                     wb_stb_i,
	input  logic                     wb_we_i,
	input  logic [`FLASH_ADDR_W-1:0] wb_adr_i,
	// write data is never stored
	input  logic [31:0]              wb_data_i,
	output logic                     wb_ack_o,
	output logic                     wb_stall_o,
	output logic                     wb_error_o,
	output logic [31:0]              wb_data_o,

	// serial flash pins
	output logic                     flash_csb_o,
	output logic                     flash_sck_o,
	output logic                     flash_io0_o,
	input  logic                     flash_io1_i
);

	// interface to buffer
	logic                  read_req_valid;
	flash_pkg::read_req_t  read_req;
	logic                  read_rsp_valid;
	flash_pkg::read_rsp_t  read_rsp;

	// buffer to reader
	logic                  fill_req_valid;
	flash_pkg::fill_req_t  fill_req;
	logic                  fill_word_valid;
	flash_pkg::fill_word_t fill_word;
	logic                  fill_done;

	wb_flash_interface u_wb_flash_interface (
		.wb_clk_i         (wb_clk_i),
		.arst_n_i         (arst_n_i),
		.wb_cyc_i         (wb_cyc_i),
		.wb_stb_i         (wb_stb_i),
		.wb_we_i          (wb_we_i),
		.wb_adr_i         (wb_adr_i),
		.wb_ack_o         (wb_ack_o),
		.wb_stall_o       (wb_stall_o),
		.wb_error_o       (wb_error_o),
		.wb_data_o        (wb_data_o),
		.read_req_valid_o (read_req_valid),
		.read_req_o       (read_req),
		.read_rsp_valid_i (read_rsp_valid),
		.read_rsp_i       (read_rsp)
	);

	// line store between bus and flash
	flash_line_buffer u_flash_line_buffer (
		.wb_clk_i          (wb_clk_i),
		.arst_n_i          (arst_n_i),
		.read_req_valid_i  (read_req_valid),
		.read_req_i        (read_req),
		.read_rsp_valid_o  (read_rsp_valid),
		.read_rsp_o        (read_rsp),
		.fill_req_valid_o  (fill_req_valid),
		.fill_req_o        (fill_req),
		.fill_word_valid_i (fill_word_valid),
		.fill_word_i       (fill_word),
		.fill_done_i       (fill_done)
	);

	spi_flash_reader u_spi_flash_reader (
		.wb_clk_i          (wb_clk_i),
		.arst_n_i          (arst_n_i),
		.fill_req_valid_i  (fill_req_valid),
		.fill_req_i        (fill_req),
		.fill_word_valid_o (fill_word_valid),
		.fill_word_o       (fill_word),
		.fill_done_o       (fill_done),
		.flash_csb_o       (flash_csb_o),
		.flash_sck_o       (flash_sck_o),
		.flash_io0_o       (flash_io0_o),
		.flash_io1_i       (flash_io1_i)
	);

endmodule

// File: design/flash_line_buffer.sv
`timescale 1ns/1ps
`include "flash_settings.svh"

module flash_line_buffer (
	input  logic                   wb_clk_i,
	input  logic                   arst_n_i,

	// word reads from the wishbone side
	input  logic                   read_req_valid_i,
	input  flash_pkg::read_req_t   read_req_i,
	output logic                   read_rsp_valid_o,
	output flash_pkg::read_rsp_t   read_rsp_o,

	// line fills from the spi reader
	output logic                   fill_req_valid_o,
	output flash_pkg::fill_req_t   fill_req_o,
	input  logic                   fill_word_valid_i,
	input  flash_pkg::fill_word_t  fill_word_i,
	input  logic                   fill_done_i
);

	localparam int WSEL_W = `FLASH_WORD_SEL_W;
	localparam int LSEL_W = `FLASH_LINE_SEL_W;
	localparam int WADR_W = $bits(flash_pkg::word_addr_t);
	// whatever is left above index and word select
	localparam int TAG_W  = WADR_W - WSEL_W - LSEL_W;

	flash_pkg::buffer_state_e state;

	// latched request address
	flash_pkg::word_addr_t req_addr;

	// line store in flops
	logic [31:0]                  line_data [`FLASH_LINE_COUNT][`FLASH_LINE_WORDS];
	logic [TAG_W-1:0]             line_tag  [`FLASH_LINE_COUNT];
	logic [`FLASH_LINE_COUNT-1:0] line_valid;

	// request address split
	logic [WSEL_W-1:0] req_word;
	logic [LSEL_W-1:0] req_line;
	logic [TAG_W-1:0]  req_tag;
	logic              hit;

	assign req_word = req_addr[WSEL_W-1:0];
	assign req_line = req_addr[WSEL_W+LSEL_W-1:WSEL_W];
	assign req_tag  = req_addr[WADR_W-1:WSEL_W+LSEL_W];
	assign hit      = line_valid[req_line] && (line_tag[req_line] == req_tag);

	// answer a hit straight from lookup, a miss once the line is in
	assign read_rsp_valid_o = ((state == flash_pkg::BS_LOOKUP) && hit)
		|| (state == flash_pkg::BS_REPLY);
	assign read_rsp_o.data  = line_data[req_line][req_word];

	// one fill per miss, line address with word select dropped
	assign fill_req_valid_o = (state == flash_pkg::BS_LOOKUP) && !hit;
	assign fill_req_o.addr  = req_addr[WADR_W-1:WSEL_W];

	always_ff @(posedge wb_clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			state      <= flash_pkg::BS_IDLE;
			line_valid <= '0;
		end else begin
			case (state)
				flash_pkg::BS_IDLE: begin
					if (read_req_valid_i) begin
						state <= flash_pkg::BS_LOOKUP;
					end
				end
				flash_pkg::BS_LOOKUP: begin
					if (hit) begin
						state <= flash_pkg::BS_IDLE;
					end else begin
						// old line is gone until the fill completes
						line_valid[req_line] <= 1'b0;
						state                <= flash_pkg::BS_FILL;
					end
				end
				flash_pkg::BS_FILL: begin
					if (fill_done_i) begin
						line_valid[req_line] <= 1'b1;
						state                <= flash_pkg::BS_REPLY;
					end
				end
				flash_pkg::BS_REPLY: begin
					state <= flash_pkg::BS_IDLE;
				end
				default: begin
					state <= flash_pkg::BS_IDLE;
				end
			endcase
		end
	end

	// address, tags and line data
	always_ff @(posedge wb_clk_i) begin
		if (read_req_valid_i) begin
			req_addr <= read_req_i.addr;
		end
		// new tag goes in with the miss
		if ((state == flash_pkg::BS_LOOKUP) && !hit) begin
			line_tag[req_line] <= req_tag;
		end
		// words land at their slot as they stream in
		if (fill_word_valid_i) begin
			line_data[req_line][fill_word_i.index] <= fill_word_i.data;
		end
	end

	// the interface keeps a single read open
	a_req_when_idle : assert property (
		@(posedge wb_clk_i) disable iff (!arst_n_i)
		read_req_valid_i |-> (state == flash_pkg::BS_IDLE)
	) else $error("read request while buffer busy");

	// the reader only streams words for a fill this block asked for
	a_word_in_fill : assert property (
		@(posedge wb_clk_i) disable iff (!arst_n_i)
		fill_word_valid_i |-> (state == flash_pkg::BS_FILL)
	) else $error("fill word outside a line fill");

endmodule

// File: design/flash_pkg.sv
`include "flash_settings.svh"

package flash_pkg;

	// byte address with the line offset stripped
	typedef logic [`FLASH_ADDR_W-3-`FLASH_WORD_SEL_W:0] line_addr_t;

	// address of one 32-bit word
	typedef logic [`FLASH_ADDR_W-3:0] word_addr_t;

	// wishbone side to line buffer
	typedef struct packed {
		word_addr_t addr;
	} read_req_t;

	typedef struct packed {
		logic [31:0] data;
	} read_rsp_t;

	// line buffer to spi reader
	typedef struct packed {
		line_addr_t addr;
	} fill_req_t;

	// one word of a line fill, index is the word slot in the line
	typedef struct packed {
		logic [31:0]                   data;
		logic [`FLASH_WORD_SEL_W-1:0]  index;
	} fill_word_t;

	// flash commands, single lane
	typedef enum logic [7:0] {
		OP_READ       = 8'h03,
		OP_RELEASE_PD = 8'hAB
	} spi_opcode_e;

	typedef enum logic [2:0] {
		RS_WAKEUP,
		RS_GAP,
		RS_IDLE,
		RS_COMMAND,
		RS_ADDRESS,
		RS_DATA
	} reader_state_e;

	typedef enum logic [1:0] {
		BS_IDLE,
		BS_LOOKUP,
		BS_FILL,
		BS_REPLY
	} buffer_state_e;

endpackage

// File: design/flash_settings.svh
`ifndef FLASH_SETTINGS_SVH
`define FLASH_SETTINGS_SVH

// byte address width on the flash side
`define FLASH_ADDR_W 24

// line geometry of the read buffer
// 32-bit words per line
`define FLASH_LINE_WORDS 4
// lines in the direct-mapped store
`define FLASH_LINE_COUNT 8

// derived select widths
`define FLASH_WORD_SEL_W ($clog2(`FLASH_LINE_WORDS))
`define FLASH_LINE_SEL_W ($clog2(`FLASH_LINE_COUNT))

// system clocks per sck half period
`define FLASH_SCK_DIV 4

`endif

// File: design/spi_flash_reader.sv
`timescale 1ns/1ps
`include "flash_settings.svh"

module spi_flash_reader (
	input  logic                   wb_clk_i,
	input  logic                   arst_n_i,

	// line fill requests and returned words
	input  logic                   fill_req_valid_i,
	input  flash_pkg::fill_req_t   fill_req_i,
	output logic                   fill_word_valid_o,
	output flash_pkg::fill_word_t  fill_word_o,
	output logic                   fill_done_o,

	// single lane spi, mode 0
	output logic                   flash_csb_o,
	output logic                   flash_sck_o,
	output logic                   flash_io0_o,
	input  logic                   flash_io1_i
);

	localparam int DIV_W = $clog2(`FLASH_SCK_DIV + 1);
	// enough to count every data bit of a line
	localparam int BIT_W = `FLASH_WORD_SEL_W + 5;

	localparam logic [DIV_W-1:0] DIV_LAST  = DIV_W'(`FLASH_SCK_DIV - 1);
	localparam logic [BIT_W-1:0] CMD_LAST  = BIT_W'(7);
	localparam logic [BIT_W-1:0] ADDR_LAST = BIT_W'(`FLASH_ADDR_W - 1);
	localparam logic [BIT_W-1:0] DATA_LAST = BIT_W'(32 * `FLASH_LINE_WORDS - 1);

	flash_pkg::reader_state_e state;

	logic [DIV_W-1:0] div_cnt;
	logic [BIT_W-1:0] bit_cnt;
	logic [BIT_W-1:0] phase_last;
	// half period boundary
	logic             tick;
	logic             sck_rise;
	logic             sck_fall;

	// outgoing command and address, msb on the wire
	logic [31:0]      tx_shift;
	// incoming byte and earlier bytes of the word
	logic [7:0]       rx_byte;
	logic [23:0]      rx_word;

	// latched fill, may arrive during wake-up
	logic                  fill_pend;
	flash_pkg::line_addr_t fill_addr;
	// current transfer belongs to a fill
	logic                  serving;

	assign tick        = (div_cnt == DIV_LAST);
	assign sck_rise    = !flash_csb_o && tick && !flash_sck_o;
	assign sck_fall    = !flash_csb_o && tick && flash_sck_o;
	assign flash_io0_o = tx_shift[31];

	// bits in the current phase
	always_comb begin
		case (state)
			flash_pkg::RS_ADDRESS: phase_last = ADDR_LAST;
			flash_pkg::RS_DATA:    phase_last = DATA_LAST;
			default:               phase_last = CMD_LAST;
		endcase
	end

	always_ff @(posedge wb_clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			state             <= flash_pkg::RS_WAKEUP;
			flash_csb_o       <= 1'b1;
			flash_sck_o       <= 1'b0;
			div_cnt           <= '0;
			bit_cnt           <= '0;
			tx_shift          <= {flash_pkg::OP_RELEASE_PD, 24'h0};
			fill_pend         <= 1'b0;
			serving           <= 1'b0;
			fill_word_valid_o <= 1'b0;
			fill_done_o       <= 1'b0;
		end else begin
			fill_word_valid_o <= 1'b0;
			fill_done_o       <= 1'b0;
			div_cnt           <= tick ? '0 : div_cnt + 1'b1;

			if (fill_req_valid_i) begin
				fill_pend <= 1'b1;
			end

			case (state)
				flash_pkg::RS_WAKEUP, flash_pkg::RS_COMMAND,
				flash_pkg::RS_ADDRESS, flash_pkg::RS_DATA: begin
					if (flash_csb_o) begin
						// first cycle after reset, open the wake-up frame
						flash_csb_o <= 1'b0;
						div_cnt     <= '0;
						bit_cnt     <= '0;
					end else if (tick && !flash_sck_o) begin
						flash_sck_o <= 1'b1;
					end else if (tick) begin
						// falling edge, next bit out
						flash_sck_o <= 1'b0;
						bit_cnt     <= bit_cnt + 1'b1;
						tx_shift    <= {tx_shift[30:0], 1'b0};
						if ((state == flash_pkg::RS_DATA) && (bit_cnt[4:0] == 5'd31)) begin
							fill_word_valid_o <= 1'b1;
						end
						if (bit_cnt == phase_last) begin
							bit_cnt <= '0;
							case (state)
								flash_pkg::RS_COMMAND: begin
									// line address with zero offset
									state    <= flash_pkg::RS_ADDRESS;
									tx_shift <= {fill_addr, {(`FLASH_WORD_SEL_W + 2){1'b0}}, 8'h00};
								end
								flash_pkg::RS_ADDRESS: begin
									state <= flash_pkg::RS_DATA;
								end
								default: begin
									// frame ends after wake-up or data
									state       <= flash_pkg::RS_GAP;
									flash_csb_o <= 1'b1;
									div_cnt     <= '0;
								end
							endcase
						end
					end
				end
				flash_pkg::RS_GAP: begin
					// close the fill once the last word is out
					if (serving) begin
						fill_done_o <= 1'b1;
						serving     <= 1'b0;
					end
					// csb high for one full sck period
					if (tick) begin
						bit_cnt <= bit_cnt + 1'b1;
						if (bit_cnt[0]) begin
							bit_cnt <= '0;
							state   <= flash_pkg::RS_IDLE;
						end
					end
				end
				flash_pkg::RS_IDLE: begin
					if (fill_pend) begin
						fill_pend   <= 1'b0;
						serving     <= 1'b1;
						state       <= flash_pkg::RS_COMMAND;
						flash_csb_o <= 1'b0;
						div_cnt     <= '0;
						bit_cnt     <= '0;
						tx_shift    <= {flash_pkg::OP_READ, 24'h0};
					end
				end
				default: begin
					state <= flash_pkg::RS_GAP;
				end
			endcase
		end
	end

	// receive path
	always_ff @(posedge wb_clk_i) begin
		if (fill_req_valid_i) begin
			fill_addr <= fill_req_i.addr;
		end
		// io1 sampled on the rising edge, msb first
		if (sck_rise && (state == flash_pkg::RS_DATA)) begin
			rx_byte <= {rx_byte[6:0], flash_io1_i};
		end
		if (sck_fall && (state == flash_pkg::RS_DATA)) begin
			// lowest address byte ends up in bits 7:0
			if (bit_cnt[2:0] == 3'd7) begin
				rx_word <= {rx_byte, rx_word[23:8]};
			end
			if (bit_cnt[4:0] == 5'd31) begin
				fill_word_o.data  <= {rx_byte, rx_word};
				fill_word_o.index <= bit_cnt[BIT_W-1:5];
			end
		end
	end

	// csb held low through command, address and data
	a_csb_framing : assert property (
		@(posedge wb_clk_i) disable iff (!arst_n_i)
		(state inside {flash_pkg::RS_COMMAND, flash_pkg::RS_ADDRESS, flash_pkg::RS_DATA})
			|-> !flash_csb_o
	) else $error("csb high inside a transfer");

	// the buffer never has two fills outstanding
	a_one_fill : assert property (
		@(posedge wb_clk_i) disable iff (!arst_n_i)
		fill_req_valid_i |-> !fill_pend && !serving
	) else $error("fill request while a fill is outstanding");

endmodule

// File: design/wb_flash_interface.sv
`timescale 1ns/1ps
`include "flash_settings.svh"

module wb_flash_interface (
	input  logic                     wb_clk_i,
	input  logic                     arst_n_i,

	// wishbone b4 pipelined slave
	input  logic                     wb_cyc_i,
	input  logic                     wb_stb_i,
	input  logic                     wb_we_i,
	input  logic [`FLASH_ADDR_W-1:0] wb_adr_i,
	output logic                     wb_ack_o,
	output logic                     wb_stall_o,
	output logic                     wb_error_o,
	output logic [31:0]              wb_data_o,

	// towards the line buffer
	output logic                     read_req_valid_o,
	output flash_pkg::read_req_t     read_req_o,
	input  logic                     read_rsp_valid_i,
	input  flash_pkg::read_rsp_t     read_rsp_i
);

	// request taken on this edge
	logic accept;
	// a buffer read is in flight
	logic read_busy;

	// stall blocks a second request while one is open
	assign accept = wb_cyc_i && wb_stb_i && !wb_stall_o;

	always_ff @(posedge wb_clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			wb_stall_o       <= 1'b0;
			wb_ack_o         <= 1'b0;
			wb_error_o       <= 1'b0;
			read_req_valid_o <= 1'b0;
			read_busy        <= 1'b0;
		end else begin
			// reads go to the buffer one cycle after acceptance
			read_req_valid_o <= accept && !wb_we_i;
			// writes are refused straight away
			wb_error_o       <= accept && wb_we_i;
			// ack follows the buffer answer by one cycle
			wb_ack_o         <= read_rsp_valid_i;

			// open from acceptance through the ack or error cycle
			if (accept) begin
				wb_stall_o <= 1'b1;
			end else if (wb_ack_o || wb_error_o) begin
				wb_stall_o <= 1'b0;
			end

			if (accept && !wb_we_i) begin
				read_busy <= 1'b1;
			end else if (read_rsp_valid_i) begin
				read_busy <= 1'b0;
			end
		end
	end

	// address and returned word
	always_ff @(posedge wb_clk_i) begin
		// byte lanes dropped, word address only
		if (accept) begin
			read_req_o.addr <= wb_adr_i[`FLASH_ADDR_W-1:2];
		end
		if (read_rsp_valid_i) begin
			wb_data_o <= read_rsp_i.data;
		end
	end

	// the buffer only answers a read this block has sent
	a_rsp_needs_req : assert property (
		@(posedge wb_clk_i) disable iff (!arst_n_i)
		read_rsp_valid_i |-> read_busy
	) else $error("read response with no read outstanding");

	// one open request at a time, ack never doubles up
	a_single_ack : assert property (
		@(posedge wb_clk_i) disable iff (!arst_n_i)
		wb_ack_o |=> !wb_ack_o
	) else $error("back to back ack on a single request");

endmodule

// File: project.f
+incdir+design
design/flash_pkg.sv
design/wb_flash_interface.sv
design/flash_line_buffer.sv
design/spi_flash_reader.sv
design/flash.sv
verification/spi_flash_model.sv
verification/flash_tb.sv

// File: verification/flash_tb.sv
`timescale 1ns/1ps
`include "flash_settings.svh"

module flash_tb;

	localparam int N_RAND   = 200;
	localparam int N_REQ    = N_RAND + 10;
	localparam int FILL_CYC = 2 * `FLASH_SCK_DIV * (8 + 24 + 32 * `FLASH_LINE_WORDS);
	localparam int WAKE_CYC = 2 * `FLASH_SCK_DIV * 12 + 40;
	localparam int LIMIT    = N_REQ * (FILL_CYC + 20) + WAKE_CYC;

	logic        clk;
	logic        arst_n;
	logic        wb_cyc;
	logic        wb_stb;
	logic        wb_we;
	logic [23:0] wb_adr;
	logic [31:0] wb_data_w;
	logic        wb_ack;
	logic        wb_stall;
	logic        wb_err;
	logic [31:0] wb_data_r;
	logic        csb;
	logic        sck;
	logic        io0;
	logic        io1;
	logic        woke;
	logic [31:0] read_cnt;
	logic [31:0] model_err;

	integer seed;
	int     pass_cnt;
	int     fail_cnt;
	int     test_start;

	// reference copy of buffer tags
	logic [16:0] ref_tag   [`FLASH_LINE_COUNT];
	logic        ref_valid [`FLASH_LINE_COUNT];

	flash u_flash (
		.wb_clk_i    (clk),
		.arst_n_i    (arst_n),
		.wb_cyc_i    (wb_cyc),
		.wb_stb_i    (wb_stb),
		.wb_we_i     (wb_we),
		.wb_adr_i    (wb_adr),
		.wb_data_i   (wb_data_w),
		.wb_ack_o    (wb_ack),
		.wb_stall_o  (wb_stall),
		.wb_error_o  (wb_err),
		.wb_data_o   (wb_data_r),
		.flash_csb_o (csb),
		.flash_sck_o (sck),
		.flash_io0_o (io0),
		.flash_io1_i (io1)
	);

	spi_flash_model u_spi_flash_model (
		.csb_i      (csb),
		.sck_i      (sck),
		.io0_i      (io0),
		.io1_o      (io1),
		.woke_o     (woke),
		.read_cnt_o (read_cnt),
		.err_cnt_o  (model_err)
	);

	always #10 clk = ~clk;

	// expected flash byte at address a
	function automatic logic [7:0] flash_byte(input logic [23:0] a);
		logic [31:0] t;
		t = {8'h00, a} * 32'd37 + {24'h000000, a[23:16]} + 32'd11;
		return t[7:0];
	endfunction

	// lowest address lands in bits 7:0
	function automatic flash_pkg::read_rsp_t expected_word(input logic [23:0] adr);
		flash_pkg::read_rsp_t r;
		logic [23:0] a;
		a = {adr[23:2], 2'b00};
		r.data = {flash_byte(a + 24'd3), flash_byte(a + 24'd2), flash_byte(a + 24'd1),
			flash_byte(a)};
		return r;
	endfunction

	task automatic check_word(input string name, input flash_pkg::read_rsp_t exp,
		input flash_pkg::read_rsp_t act);
		if (exp !== act) begin
			$display("** Error: %s expected %h got %h", name, exp.data, act.data);
			fail_cnt++;
		end else begin
			pass_cnt++;
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (exp !== act) begin
			$display("** Error: %s expected %h got %h", name, exp, act);
			fail_cnt++;
		end else begin
			pass_cnt++;
		end
	endtask

	task automatic check_latency(input string name, input int exp, input int act);
		if (exp != act) begin
			$display("** Error: %s expected %h got %h", name, exp, act);
			fail_cnt++;
		end else begin
			pass_cnt++;
		end
	endtask

	// one wishbone request, hold keeps stb high while the request is open
	task automatic run_request(input logic we, input logic [23:0] adr, input logic hold,
		output int lat, output logic got_ack, output logic got_err,
		output flash_pkg::read_rsp_t rsp);
		int extra;
		@(posedge clk);
		wb_cyc    <= 1'b1;
		wb_stb    <= 1'b1;
		wb_we     <= we;
		wb_adr    <= adr;
		wb_data_w <= $random(seed);
		@(negedge clk);
		check_flag("wb_stall_o", 1'b0, wb_stall);
		// accepting edge
		@(posedge clk);
		if (!hold) begin
			wb_stb <= 1'b0;
		end
		lat     = 0;
		got_ack = 1'b0;
		got_err = 1'b0;
		// cycles up to the edge that samples ack or error
		while (!got_ack && !got_err) begin
			@(negedge clk);
			lat++;
			got_ack = wb_ack;
			got_err = wb_err;
			check_flag("wb_stall_o", 1'b1, wb_stall);
		end
		rsp.data = wb_data_r;
		@(posedge clk);
		wb_stb <= 1'b0;
		wb_cyc <= 1'b0;
		// pulse is one cycle, nothing more may follow
		extra = 0;
		repeat (4) begin
			@(negedge clk);
			if (wb_ack || wb_err) begin
				extra++;
			end
		end
		check_flag("wb_ack_o", 1'b0, extra != 0);
	endtask

	// read with hit or miss predicted by the reference copy
	task automatic read_and_check(input logic [23:0] adr, input logic hold);
		int                   lat;
		logic                 got_ack;
		logic                 got_err;
		logic                 hit;
		logic [2:0]           idx;
		flash_pkg::read_rsp_t rsp;
		idx = adr[6:4];
		hit = ref_valid[idx] && (ref_tag[idx] == adr[23:7]);
		run_request(1'b0, adr, hold, lat, got_ack, got_err, rsp);
		check_flag("wb_ack_o", 1'b1, got_ack);
		check_flag("wb_error_o", 1'b0, got_err);
		check_word("wb_data_o", expected_word(adr), rsp);
		if (hit) begin
			check_latency("wb_ack_o latency", 3, lat);
		end else begin
			// a fill always takes longer than a hit
			check_flag("wb_ack_o late on miss", 1'b1, lat > 3);
			ref_valid[idx] = 1'b1;
			ref_tag[idx]   = adr[23:7];
		end
	endtask

	task automatic end_test(input string name);
		if (fail_cnt == test_start) begin
			$display("test %s: ok", name);
		end else begin
			$display("test %s: %0d errors", name, fail_cnt - test_start);
		end
		test_start = fail_cnt;
	endtask

	// watchdog sized from the worst case fill per request
	initial begin
		repeat (LIMIT) @(posedge clk);
		$display("timeout: the run did not finish within %0d cycles", LIMIT);
		$display("CHECKS FAILED");
		$finish;
	end

	initial begin
		int                   lat;
		int                   reads_before;
		logic                 got_ack;
		logic                 got_err;
		logic [16:0]          tags [4];
		logic [31:0]          r;
		flash_pkg::read_rsp_t rsp;
		seed       = 32'h9a7d_a819;
		pass_cnt   = 0;
		fail_cnt   = 0;
		test_start = 0;
		clk        = 1'b0;
		arst_n     = 1'b0;
		wb_cyc     = 1'b0;
		wb_stb     = 1'b0;
		wb_we      = 1'b0;
		wb_adr     = '0;
		wb_data_w  = '0;
		for (int i = 0; i < `FLASH_LINE_COUNT; i++) begin
			ref_valid[i] = 1'b0;
			ref_tag[i]   = '0;
		end
		tags[0] = 17'h00000;
		tags[1] = 17'h1a5c3;
		tags[2] = 17'h0ff01;
		tags[3] = 17'h02468;
		repeat (4) @(posedge clk);
		arst_n <= 1'b1;

		// first read fetches from flash after wake-up
		read_and_check(24'h01_2344, 1'b0);
		check_flag("model wake-up seen", 1'b1, woke);
		check_flag("one flash read", 1'b1, read_cnt == 32'd1);
		end_test("wake-up and first read");

		// same line, served from the buffer
		reads_before = read_cnt;
		read_and_check(24'h01_2348, 1'b0);
		read_and_check(24'h01_2344, 1'b0);
		check_flag("flash transfer on hit", 1'b0, read_cnt != reads_before);
		end_test("hit latency");

		// writes are refused
		reads_before = read_cnt;
		run_request(1'b1, 24'h00_0100, 1'b0, lat, got_ack, got_err, rsp);
		check_flag("wb_error_o", 1'b1, got_err);
		check_flag("wb_ack_o", 1'b0, got_ack);
		check_latency("wb_error_o latency", 1, lat);
		check_flag("flash transfer on write", 1'b0, read_cnt != reads_before);
		end_test("write refused");

		// stb held through an open hit and an open miss
		read_and_check(24'h01_234c, 1'b1);
		read_and_check(24'h7f_0010, 1'b1);
		end_test("stall while open");

		// shared indices, mixed tags
		for (int n = 0; n < N_RAND; n++) begin
			r = $random(seed);
			read_and_check({tags[r[9:8]], r[6:4], r[3:2], r[1:0]}, 1'b0);
		end
		end_test("random reads");

		if (model_err != 0) begin
			$display("flash model reported %0d protocol problems", model_err);
			fail_cnt++;
		end
		$display("checks passed %0d, failed %0d", pass_cnt, fail_cnt);
		if (fail_cnt == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

// File: verification/spi_flash_model.sv
`timescale 1ns/1ps

module spi_flash_model (
	input  logic        csb_i,
	input  logic        sck_i,
	input  logic        io0_i,
	output logic        io1_o,
	output logic        woke_o,
	output logic [31:0] read_cnt_o,
	output logic [31:0] err_cnt_o
);

	// rising sck edges seen in the current frame
	logic [7:0]  bit_cnt = '0;
	logic [7:0]  cmd     = '0;
	logic [23:0] addr    = '0;
	logic [7:0]  next_cmd;
	logic [7:0]  off;
	// byte being shifted out in the data phase
	logic [7:0]  out_byte;

	initial begin
		io1_o      = 1'b0;
		woke_o     = 1'b0;
		read_cnt_o = '0;
		err_cnt_o  = '0;
	end

	// flash contents, computed from the byte address
	function automatic logic [7:0] pattern_byte(input logic [23:0] a);
		logic [31:0] t;
		t = {8'h00, a} * 32'd37 + {24'h000000, a[23:16]} + 32'd11;
		return t[7:0];
	endfunction

	assign next_cmd = {cmd[6:0], io0_i};
	assign off      = bit_cnt - 8'd32;
	assign out_byte = pattern_byte(addr + {19'h0, off[7:3]});

	// mode 0, io0 sampled on the rising edge
	always @(posedge sck_i or posedge csb_i) begin
		if (csb_i) begin
			bit_cnt <= '0;
		end else begin
			bit_cnt <= bit_cnt + 8'd1;
			if (bit_cnt < 8'd8) begin
				cmd <= next_cmd;
			end else if (bit_cnt < 8'd32) begin
				addr <= {addr[22:0], io0_i};
			end
			// opcode complete on the eighth bit
			if (bit_cnt == 8'd7) begin
				case (next_cmd)
					8'hAB: woke_o <= 1'b1;
					8'h03: begin
						read_cnt_o <= read_cnt_o + 32'd1;
						if (!woke_o) begin
							$display("flash model: read command arrived before wake-up");
							err_cnt_o <= err_cnt_o + 32'd1;
						end
					end
					default: begin
						$display("flash model: unknown opcode %h", next_cmd);
						err_cnt_o <= err_cnt_o + 32'd1;
					end
				endcase
			end
		end
	end

	// data out on the falling edge, msb of each byte first
	always @(negedge sck_i) begin
		if (!csb_i && (cmd == 8'h03) && (bit_cnt >= 8'd32)) begin
			io1_o <= out_byte[3'd7 - off[2:0]];
		end
	end

endmodule
